//--- bench/color_track_patterns.txt
# name presses col_first col_last row_first row_last fg bg mode centroid proximity
# presses add to the mode left by the previous line; colors 12-bit rgb hex, mode and centroid binary
none_all        0  10 20 10 20 f00 000 000 00011000 7
red_edge_left   1   8 15  6 53 f00 000 100 00000001 4
red_edge_right  0  64 71  6 53 f00 7ff 100 10000000 4
red_middle      0  36 43 20 35 f00 0f0 100 00011000 3
green_bin1      1  16 23 10 29 0f0 f0f 010 00000010 3
green_bin2      0  24 31 10 17 0f0 000 010 00000100 2
blue_bin3       1  32 39  6 53 00f 888 001 00001000 4
blue_bin4       0  40 47  6 53 00f ff0 001 00010000 4
yellow_bin6     1  56 63  6 37 ff0 f00 110 01000000 4
yellow_bin5     0  48 55  6 13 ff0 000 110 00100000 2
magenta_few     1  10 13 10 17 f0f f00 101 00000000 1
magenta_reject  0   8 71  6 53 f00 0f0 101 00000000 0
cyan_left_half  1   8 39  6 53 0ff 00f 011 00000010 7
cyan_right      0  40 71  6 37 08f 000 011 01000000 6
white_band      1   8 71  6 13 fff 777 111 00011000 5
white_outside   0   0 11  0 59 ccc 000 111 00000001 3
wrap_none       1  20 30 20 30 123 456 000 00011000 7
blue_again      3  44 71 30 53 00f 80f 001 01000000 5
blue_full_turn  8   8 23  6 29 119 000 001 00000001 4

//--- bench/color_track_checks.svh
`ifndef color_track_checks_svh
`define color_track_checks_svh

  int pass_count = 0; // checks that matched
  int err_count  = 0; // checks that failed, plus setup errors

  task automatic check_mode(input color_track_pkg::filter_mode_e got,
                            input color_track_pkg::filter_mode_e exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0.1f ns: %s got %03b expected %03b", $realtime, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_pixel(input color_track_pkg::pixel_t got,
                             input color_track_pkg::pixel_t exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0.1f ns: %s got %03h expected %03h", $realtime, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_centroid(input logic [color_track_pkg::leds-1:0] got,
                                input logic [color_track_pkg::leds-1:0] exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0.1f ns: %s got %08b expected %08b", $realtime, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_proximity(input logic [color_track_pkg::prox_w-1:0] got,
                                 input logic [color_track_pkg::prox_w-1:0] exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0.1f ns: %s got %0d expected %0d", $realtime, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  // memory addresses, orig_addr and proc_addr
  task automatic check_addr(input logic [color_track_pkg::addr_w-1:0] got,
                            input logic [color_track_pkg::addr_w-1:0] exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0.1f ns: %s got %0d expected %0d", $realtime, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

  // single control bits such as proc_we and new_centroid
  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0.1f ns: %s got %b expected %b", $realtime, what, got, exp);
    end else begin
      pass_count++;
    end
  endtask

`endif

//--- bench/color_track_tb.sv
module color_track_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // one line of the pattern file
  typedef struct packed {
    logic [3:0]                         presses;   // presses added by this test
    logic [color_track_pkg::col_w-1:0]  col_first;
    logic [color_track_pkg::col_w-1:0]  col_last;
    logic [color_track_pkg::row_w-1:0]  row_first;
    logic [color_track_pkg::row_w-1:0]  row_last;
    color_track_pkg::pixel_t            fg;        // rectangle color
    color_track_pkg::pixel_t            bg;        // background color
    color_track_pkg::filter_mode_e      mode;
    logic [color_track_pkg::leds-1:0]   centroid;
    logic [color_track_pkg::prox_w-1:0] prox;
  } pattern_t;

  logic                               clk;
  logic                               rst;
  logic                               proc_ctrl;
  color_track_pkg::pixel_t            orig_pxl;
  logic [color_track_pkg::addr_w-1:0] orig_addr;
  logic                               proc_we;
  color_track_pkg::pixel_t            proc_pxl;
  logic [color_track_pkg::addr_w-1:0] proc_addr;
  logic [color_track_pkg::leds-1:0]   centroid;
  logic                               new_centroid;
  logic [color_track_pkg::prox_w-1:0] proximity;
  color_track_pkg::filter_mode_e      rgbfilter;

  color_track_pkg::pixel_t img [color_track_pkg::img_pxls]; // source image memory
  pattern_t                pats[$];
  string                   names[$];
  logic                    loaded = 1'b0; // patterns read, watchdog may start

  `include "color_track_checks.svh"

  color_track #(.min_color_pixels(32)) color_track_inst (
    .clk          (clk),
    .rst          (rst),
    .proc_ctrl    (proc_ctrl),
    .orig_pxl     (orig_pxl),
    .orig_addr    (orig_addr),
    .proc_we      (proc_we),
    .proc_pxl     (proc_pxl),
    .proc_addr    (proc_addr),
    .centroid     (centroid),
    .new_centroid (new_centroid),
    .proximity    (proximity),
    .rgbfilter    (rgbfilter)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 250 MHz
  end

  always @(posedge clk)
    orig_pxl <= img[orig_addr]; // one cycle read latency

  // expected output pixel, kept when each channel msb equals its mode bit
  function automatic color_track_pkg::pixel_t expect_pixel(input color_track_pkg::pixel_t p,
                                                           input color_track_pkg::filter_mode_e m);
    logic [2:0] bits;
    logic       keep;
    bits = m;
    keep = (p.red[3] == bits[2]) && (p.green[3] == bits[1]) && (p.blue[3] == bits[0]);
    if (m == color_track_pkg::mode_none)
      keep = 1'b1; // no filter, everything passes
    if (keep)
      return p;
    return '0;
  endfunction

  task automatic load_patterns();
    int    fd;
    int    n;
    string line;
    string name;
    int    presses, c0, c1, r0, r1;
    int    fg, bg, mode, cen, prox;
    pattern_t p;
    fd = $fopen("bench/color_track_patterns.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("could not open the pattern file bench/color_track_patterns.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin // skip comments and blank lines
          n = $sscanf(line, "%s %d %d %d %d %d %h %h %b %b %d", name, presses,
                      c0, c1, r0, r1, fg, bg, mode, cen, prox);
          if (n == 11) begin
            p.presses   = 4'(presses);
            p.col_first = color_track_pkg::col_w'(c0);
            p.col_last  = color_track_pkg::col_w'(c1);
            p.row_first = color_track_pkg::row_w'(r0);
            p.row_last  = color_track_pkg::row_w'(r1);
            p.fg        = 12'(fg);
            p.bg        = 12'(bg);
            p.mode      = color_track_pkg::filter_mode_e'(mode);
            p.centroid  = color_track_pkg::leds'(cen);
            p.prox      = color_track_pkg::prox_w'(prox);
            pats.push_back(p);
            names.push_back(name);
          end else begin
            err_count++;
            $display("pattern line could not be read: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // rectangle on background, written between rising edges
  task automatic fill_image(input pattern_t p);
    int row;
    int col;
    @(negedge clk);
    for (int a = 0; a < color_track_pkg::img_pxls; a++) begin
      row = a / color_track_pkg::img_cols;
      col = a % color_track_pkg::img_cols;
      if (col >= p.col_first && col <= p.col_last && row >= p.row_first && row <= p.row_last)
        img[a] = p.fg;
      else
        img[a] = p.bg;
    end
  endtask

  task automatic press_button(input int n);
    repeat (n) begin
      @(posedge clk);
      proc_ctrl <= 1'b1;
      repeat (4) @(posedge clk); // held 4 cycles
      proc_ctrl <= 1'b0;
      repeat (4) @(posedge clk); // released 4 cycles
    end
  endtask

  // runs to the next new_centroid strobe, optionally checking the scan and every written pixel
  task automatic wait_result(input logic check_pixels, input color_track_pkg::filter_mode_e mode);
    logic [color_track_pkg::addr_w-1:0] last_addr; // orig_addr one cycle back
    logic [color_track_pkg::addr_w-1:0] next_addr; // where the scan must be now
    last_addr = orig_addr;
    do begin
      @(negedge clk);
      if (check_pixels) begin
        if (last_addr == color_track_pkg::addr_w'(color_track_pkg::img_pxls - 1))
          next_addr = '0; // wraps after the last pixel
        else
          next_addr = last_addr + 1'b1;
        check_addr(orig_addr, next_addr, "orig_addr step");
        check_addr(proc_addr, last_addr, "proc_addr one cycle behind orig_addr");
        check_pixel(proc_pxl, expect_pixel(img[proc_addr], mode),
                    $sformatf("proc_pxl at address %0d", proc_addr));
      end
      last_addr = orig_addr;
    end while (!new_centroid);
    if (check_pixels)
      check_addr(orig_addr, '0, "orig_addr while new_centroid is high"); // strobe follows 4799
  endtask

  initial begin
    wait (loaded);
    #((pats.size() + 1) * 3 * color_track_pkg::img_pxls * 4 + 10000);
    $display("timeout: the DUT stopped delivering frame results");
    $display("Test failed");
    $finish;
  end

  initial begin
    int err_before;
    rst       = 1'b1;
    proc_ctrl = 1'b0;
    orig_pxl  = '0;
    for (int a = 0; a < color_track_pkg::img_pxls; a++)
      img[a] = '0; // dark frame until the first test
    load_patterns();
    loaded = 1'b1;

    err_before = err_count;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag(proc_we, 1'b0, "proc_we during reset");
    repeat (2) @(posedge clk);
    rst <= 1'b0; // released after 4 cycles
    @(negedge clk);
    check_mode(rgbfilter, color_track_pkg::mode_none, "filter mode after reset");
    do begin
      @(negedge clk);
      check_flag(new_centroid, 1'b0, "new_centroid before the first frame end");
    end while (orig_addr != color_track_pkg::addr_w'(color_track_pkg::img_pxls - 1));
    check_flag(proc_we, 1'b1, "proc_we after reset");
    $display("test 0 reset_state: %s", (err_count == err_before) ? "pass" : "fail");

    foreach (pats[i]) begin
      err_before = err_count;
      fill_image(pats[i]);
      press_button(pats[i].presses);
      wait_result(1'b0, pats[i].mode); // this frame may mix old and new settings
      wait_result(1'b1, pats[i].mode);
      check_mode(rgbfilter, pats[i].mode, "filter mode");
      check_centroid(centroid, pats[i].centroid, "centroid");
      check_proximity(proximity, pats[i].prox, "proximity");
      $display("test %0d %s: %s", i + 1, names[i], (err_count == err_before) ? "pass" : "fail");
    end

    $display("checks passed %0d, errors %0d", pass_count, err_count);
    if (err_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- design/bin_accum.sv
module bin_accum (
  input  logic                       clk,
  input  logic                       rst,
  input  color_track_pkg::scan_pos_t pos,
  input  logic                       hit,
  output color_track_pkg::bin_sums_t sums
);

  logic count_en;
  logic in_left;  // bins 0..3
  logic in_01;
  logic in_012;
  logic in_67;
  logic in_567;
  logic in_edge0;
  logic in_edge7;

  // a matching pixel inside the inner frame
  assign count_en = pos.in_frame & hit;

  // group membership of the current bin
  assign in_left  = ~pos.bin[2];
  assign in_01    = (pos.bin <= 3'd1);
  assign in_012   = (pos.bin <= 3'd2);
  assign in_67    = (pos.bin >= 3'd6);
  assign in_567   = (pos.bin >= 3'd5);
  assign in_edge0 = (pos.bin == 3'd0);
  assign in_edge7 = (pos.bin == 3'd7);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sums <= '0;
    end else if (pos.frame_end) begin
      sums <= '0; // fresh counts for the next frame, the decision latches the old ones
    end else if (count_en) begin
      sums.total <= sums.total + 1'b1;
      if (in_left)
        sums.left <= sums.left + 1'b1;
      else
        sums.right <= sums.right + 1'b1;
      if (in_01)
        sums.bin01 <= sums.bin01 + 1'b1;
      if (in_012)
        sums.bin012 <= sums.bin012 + 1'b1;
      if (in_67)
        sums.bin67 <= sums.bin67 + 1'b1;
      if (in_567)
        sums.bin567 <= sums.bin567 + 1'b1;
      if (in_edge0)
        sums.edge0 <= sums.edge0 + 1'b1; // leftmost 8 columns
      if (in_edge7)
        sums.edge7 <= sums.edge7 + 1'b1; // rightmost 8 columns
    end
  end

endmodule

//--- design/centroid_decide.sv
module centroid_decide #(
  parameter int min_color_pixels = 32 // below this the detection is treated as noise
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  color_track_pkg::bin_sums_t           sums,
  input  logic                                 frame_end,
  output logic [color_track_pkg::leds-1:0]     centroid,
  output logic                                 new_centroid,
  output logic [color_track_pkg::prox_w-1:0]   proximity
);

  logic [color_track_pkg::half_w-1:0] half;    // total / 2
  logic [color_track_pkg::half_w-1:0] div;     // total / 16, centre tolerance
  logic [color_track_pkg::half_w-1:0] absdif;  // |left - right|
  logic                               left_more;
  logic [color_track_pkg::leds-1:0]   centroid_nxt;
  logic [color_track_pkg::prox_w-1:0] prox_nxt;

  assign half      = sums.total[color_track_pkg::count_w-1:1];
  assign div       = color_track_pkg::half_w'(sums.total[color_track_pkg::count_w-1:4]);
  assign left_more = (sums.left > sums.right);
  assign absdif    = left_more ? (sums.left - sums.right) : (sums.right - sums.left);

  // walk in from the edges, first group holding half the pixels wins
  always_comb begin
    centroid_nxt = '0;
    if (sums.total <= min_color_pixels) begin
      centroid_nxt = '0; // nothing worth tracking
    end else if (absdif < div) begin
      centroid_nxt[4:3] = 2'b11; // balanced, object in the middle
    end else if (left_more) begin
      if (sums.edge0 >= half)
        centroid_nxt[0] = 1'b1;
      else if (sums.bin01 >= half)
        centroid_nxt[1] = 1'b1;
      else if (sums.bin012 >= half)
        centroid_nxt[2] = 1'b1;
      else if (sums.left > half)
        centroid_nxt[3] = 1'b1;
    end else begin
      // mirror image for the right side
      if (sums.edge7 >= half)
        centroid_nxt[7] = 1'b1;
      else if (sums.bin67 >= half)
        centroid_nxt[6] = 1'b1;
      else if (sums.bin567 >= half)
        centroid_nxt[5] = 1'b1;
      else if (sums.right > half)
        centroid_nxt[4] = 1'b1;
    end
  end

  // proximity from the matched area, roughly one level per doubling
  always_comb begin
    if (sums.total >= 12'd1536)
      prox_nxt = 3'd7; // half the inner frame or more
    else if (sums.total >= 12'd1024)
      prox_nxt = 3'd6;
    else if (sums.total >= 12'd512)
      prox_nxt = 3'd5;
    else if (sums.total >= 12'd256)
      prox_nxt = 3'd4;
    else if (sums.total >= 12'd128)
      prox_nxt = 3'd3;
    else if (sums.total >= 12'd64)
      prox_nxt = 3'd2;
    else if (sums.total >= 12'd32)
      prox_nxt = 3'd1;
    else
      prox_nxt = 3'd0; // far or absent
  end

  // sums still hold the whole frame on the frame_end edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      centroid     <= '0;
      proximity    <= '0;
      new_centroid <= 1'b0;
    end else if (frame_end) begin
      centroid     <= centroid_nxt;
      proximity    <= prox_nxt;
      new_centroid <= 1'b1;
    end else begin
      new_centroid <= 1'b0; // single cycle strobe
    end
  end

  centroid_shape: assert property (@(posedge clk) disable iff (rst)
    new_centroid |-> ($onehot0(centroid) || centroid == 8'b0001_1000))
    else $error("centroid is neither one-hot nor the middle pair");

endmodule

//--- design/color_filter.sv
module color_filter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          proc_ctrl, // push button, asynchronous
  input  color_track_pkg::pixel_t       orig_pxl,
  output color_track_pkg::filter_mode_e rgbfilter,
  output logic                          hit,
  output color_track_pkg::pixel_t       proc_pxl
);

  logic                          btn_s1;   // first sync stage
  logic                          btn_s2;   // second sync stage
  logic                          btn_prev; // last synchronized value
  logic                          btn_rise;
  color_track_pkg::filter_mode_e mode_nxt;
  logic [2:0]                    pxl_msb;  // {r,g,b} msbs

  // two flop synchronizer and history for edge detection
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      btn_s1   <= 1'b0;
      btn_s2   <= 1'b0;
      btn_prev <= 1'b0;
    end else begin
      btn_s1   <= proc_ctrl;
      btn_s2   <= btn_s1;
      btn_prev <= btn_s2;
    end
  end

  assign btn_rise = btn_s2 & ~btn_prev;

  // button order: none, r, g, b, rg, rb, gb, rgb, back to none
  always_comb begin
    case (rgbfilter)
      color_track_pkg::mode_none:    mode_nxt = color_track_pkg::mode_red;
      color_track_pkg::mode_red:     mode_nxt = color_track_pkg::mode_green;
      color_track_pkg::mode_green:   mode_nxt = color_track_pkg::mode_blue;
      color_track_pkg::mode_blue:    mode_nxt = color_track_pkg::mode_yellow;
      color_track_pkg::mode_yellow:  mode_nxt = color_track_pkg::mode_magenta;
      color_track_pkg::mode_magenta: mode_nxt = color_track_pkg::mode_cyan;
      color_track_pkg::mode_cyan:    mode_nxt = color_track_pkg::mode_white;
      default:                       mode_nxt = color_track_pkg::mode_none; // white wraps
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      rgbfilter <= color_track_pkg::mode_none;
    else if (btn_rise)
      rgbfilter <= mode_nxt;
  end

  // classification looks at the channel msbs only
  assign pxl_msb = {orig_pxl.red[3], orig_pxl.green[3], orig_pxl.blue[3]};

  // exact match, so red mode rejects yellow, magenta and white
  assign hit = (rgbfilter == color_track_pkg::mode_none) || (pxl_msb == rgbfilter);

  assign proc_pxl = hit ? orig_pxl : '0; // rejected pixels are blacked out

  // mode holds unless the synchronized button went from low to high
  mode_on_edge: assert property (@(posedge clk) disable iff (rst)
    !$rose(btn_s2) |=> $stable(rgbfilter))
    else $error("filter mode changed without a button edge");

endmodule

//--- design/color_track.sv
module color_track #(
  parameter int min_color_pixels = 32
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 proc_ctrl,  // filter select button
  input  color_track_pkg::pixel_t              orig_pxl,   // image memory read data
  output logic [color_track_pkg::addr_w-1:0]   orig_addr,
  output logic                                 proc_we,
  output color_track_pkg::pixel_t              proc_pxl,
  output logic [color_track_pkg::addr_w-1:0]   proc_addr,
  output logic [color_track_pkg::leds-1:0]     centroid,
  output logic                                 new_centroid,
  output logic [color_track_pkg::prox_w-1:0]   proximity,
  output color_track_pkg::filter_mode_e        rgbfilter
);

  color_track_pkg::scan_pos_t pos;  // data phase position
  color_track_pkg::bin_sums_t sums;
  logic                       hit;

  // processed memory written every cycle once out of reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      proc_we <= 1'b0;
    else
      proc_we <= 1'b1;
  end

  frame_scan frame_scan_inst (
    .clk       (clk),
    .rst       (rst),
    .orig_addr (orig_addr),
    .proc_addr (proc_addr),
    .pos       (pos)
  );

  color_filter color_filter_inst (
    .clk       (clk),
    .rst       (rst),
    .proc_ctrl (proc_ctrl),
    .orig_pxl  (orig_pxl),
    .rgbfilter (rgbfilter),
    .hit       (hit),
    .proc_pxl  (proc_pxl)
  );

  bin_accum bin_accum_inst (
    .clk  (clk),
    .rst  (rst),
    .pos  (pos),
    .hit  (hit),
    .sums (sums)
  );

  centroid_decide #(
    .min_color_pixels (min_color_pixels)
  ) centroid_decide_inst (
    .clk          (clk),
    .rst          (rst),
    .sums         (sums),
    .frame_end    (pos.frame_end),
    .centroid     (centroid),
    .new_centroid (new_centroid),
    .proximity    (proximity)
  );

endmodule

//--- design/color_track_pkg.sv
package color_track_pkg;

  // frame geometry, 80x60 sensor output
  localparam int img_cols = 80;
  localparam int img_rows = 60;
  localparam int img_pxls = img_cols * img_rows; // 4800
  localparam int addr_w   = 13;                  // 4800 fits in 2^13
  localparam int col_w    = 7;                   // 0 to 79
  localparam int row_w    = 6;                   // 0 to 59

  // inner frame, 8 columns and 6 rows cut at each side
  localparam int in_col_first = 8;
  localparam int in_col_last  = 71;
  localparam int in_row_first = 6;
  localparam int in_row_last  = 53;

  // inner frame split into 8 bins of 8 columns
  localparam int hist_bins = 8;
  localparam int bin_w     = 3;

  localparam int count_w = 12; // up to 64x48 = 3072 pixels
  localparam int half_w  = 11; // half of the inner frame, 1536
  localparam int edge_w  = 9;  // one bin, 8x48 = 384

  localparam int prox_w = 3;   // 0 far, 7 close
  localparam int leds   = 8;   // one-hot centroid, bit 0 is the left edge

  // 12-bit rgb 4:4:4, red in the top nibble
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_t;

  // one bit per channel {r,g,b}, members listed in button order
  typedef enum logic [2:0] {
    mode_none    = 3'b000, // no filter, every pixel kept
    mode_red     = 3'b100,
    mode_green   = 3'b010,
    mode_blue    = 3'b001,
    mode_yellow  = 3'b110,
    mode_magenta = 3'b101,
    mode_cyan    = 3'b011,
    mode_white   = 3'b111
  } filter_mode_e;

  // position of the pixel now on orig_pxl
  typedef struct packed {
    logic             in_frame;  // inside the 64x48 inner frame
    logic [bin_w-1:0] bin;       // inner column / 8
    logic             frame_end; // address counter at 4799
  } scan_pos_t;

  // per-frame matching pixel counts
  typedef struct packed {
    logic [count_w-1:0] total;
    logic [half_w-1:0]  left;   // bins 0..3
    logic [half_w-1:0]  right;  // bins 4..7
    logic [half_w-1:0]  bin01;
    logic [half_w-1:0]  bin012;
    logic [half_w-1:0]  bin67;
    logic [half_w-1:0]  bin567;
    logic [edge_w-1:0]  edge0;
    logic [edge_w-1:0]  edge7;
  } bin_sums_t;

endpackage

//--- design/frame_scan.sv
module frame_scan (
  input  logic                                clk,
  input  logic                                rst,
  output logic [color_track_pkg::addr_w-1:0]  orig_addr,
  output logic [color_track_pkg::addr_w-1:0]  proc_addr,
  output color_track_pkg::scan_pos_t          pos
);

  logic [color_track_pkg::addr_w-1:0] addr_cnt;  // address phase pixel counter
  logic [color_track_pkg::col_w-1:0]  col;       // address phase column
  logic [color_track_pkg::col_w-1:0]  col_d;     // data phase column
  logic [color_track_pkg::col_w-1:0]  col_in;    // column relative to inner frame
  logic [color_track_pkg::row_w-1:0]  row;
  logic                               end_frame;
  logic                               end_line;

  assign end_frame = (addr_cnt == color_track_pkg::addr_w'(color_track_pkg::img_pxls - 1));
  assign end_line  = (col == color_track_pkg::col_w'(color_track_pkg::img_cols - 1));

  // pixel address, memory answers one cycle later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      addr_cnt  <= '0;
      proc_addr <= '0;
    end else begin
      proc_addr <= addr_cnt; // processed pixel goes back to the address it came from
      if (end_frame)
        addr_cnt <= '0;
      else
        addr_cnt <= addr_cnt + 1'b1;
    end
  end

  assign orig_addr = addr_cnt;

  // column 0..79, plus a copy aligned with the returned pixel
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      col   <= '0;
      col_d <= '0;
    end else begin
      col_d <= col;
      if (end_line)
        col <= '0;
      else
        col <= col + 1'b1;
    end
  end

  // row is not delayed. it steps together with the column wrap, so only
  // the data phase of column 79 sees the next row, and that column is
  // outside the inner frame anyway
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      row <= '0;
    else if (end_frame)
      row <= '0;
    else if (end_line)
      row <= row + 1'b1;
  end

  assign col_in = col_d - color_track_pkg::col_w'(color_track_pkg::in_col_first);

  assign pos.in_frame = (col_d >= color_track_pkg::in_col_first) &&
                        (col_d <= color_track_pkg::in_col_last)  &&
                        (row   >= color_track_pkg::in_row_first) &&
                        (row   <= color_track_pkg::in_row_last);
  assign pos.bin       = col_in[color_track_pkg::bin_w+2:3]; // 64 columns -> 8 bins
  assign pos.frame_end = end_frame;

  col_in_range: assert property (@(posedge clk) disable iff (rst)
    col <= color_track_pkg::col_w'(color_track_pkg::img_cols - 1))
    else $error("column counter ran past the end of the line");

endmodule

//--- list.f
+incdir+bench
design/color_track_pkg.sv
design/frame_scan.sv
design/color_filter.sv
design/bin_accum.sv
design/centroid_decide.sv
design/color_track.sv
bench/color_track_tb.sv
